/* md_pkg.sv */
`default_nettype none

package md_pkg;

    // ========================================
    // Fixed-point types
    // ========================================

    // Signed Q16.16 used for positions, forces and step sizes
    typedef logic signed [31:0] coord_t;
    typedef logic [5:0]         atom_idx_t;
    typedef logic [15:0]        iter_t;

    localparam int MAX_ATOMS = 64;

    // ========================================
    // Physics constants
    // ========================================

    // Annealing schedule of the step size
    localparam coord_t INITIAL_STEP   = 32'sh0000_0200;
    localparam coord_t COOLING_FACTOR = 32'sh0000_F000;

    // Largest move of one atom along one axis per iteration
    localparam coord_t MOVE_LIMIT = 32'sh0000_8000;

    // Spring constant shared by every bond
    localparam coord_t BOND_K = 32'sh0000_4000;

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        BOND,
        BOND_DRAIN,
        APPLY,
        APPLY_DRAIN,
        COOL
    } md_state_e;

    // Q16.16 product, the arithmetic shift floors toward minus infinity
    function automatic coord_t q_mult(input coord_t a, input coord_t b);
        logic signed [63:0] prod;
        prod = 64'(a) * 64'(b);
        return coord_t'(prod[47:16]);
    endfunction

endpackage

`default_nettype wire

/* md_ifs.sv */
`timescale 1ns/10ps
`default_nettype none

// Combinational coordinate read port
interface coord_rd_if;
    import md_pkg::*;

    atom_idx_t addr;
    coord_t    x;
    coord_t    y;
    coord_t    z;

    modport client (output addr, input x, y, z);
    modport store  (input addr, output x, y, z);
endinterface

// One bond force with the two atoms it acts on
interface pair_force_if;
    import md_pkg::*;

    logic      valid;
    atom_idx_t idx_a;
    atom_idx_t idx_b;
    coord_t    fx;
    coord_t    fy;
    coord_t    fz;

    modport src (output valid, idx_a, idx_b, fx, fy, fz);
    modport dst (input  valid, idx_a, idx_b, fx, fy, fz);
endinterface

`default_nettype wire

/* atom_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module atom_regfile (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 load_en_i,
    input  md_pkg::atom_idx_t   load_addr_i,
    input  md_pkg::coord_t      load_x_i,
    input  md_pkg::coord_t      load_y_i,
    input  md_pkg::coord_t      load_z_i,
    input  wire                 upd_we_i,
    input  md_pkg::atom_idx_t   upd_addr_i,
    input  md_pkg::coord_t      upd_x_i,
    input  md_pkg::coord_t      upd_y_i,
    input  md_pkg::coord_t      upd_z_i,
    coord_rd_if.store           rd_a,
    coord_rd_if.store           rd_b,
    coord_rd_if.store           rd_c,
    input  md_pkg::atom_idx_t   rd_addr_i,
    output md_pkg::coord_t      rd_x_o,
    output md_pkg::coord_t      rd_y_o,
    output md_pkg::coord_t      rd_z_o
);
    import md_pkg::*;

    coord_t mem_x [MAX_ATOMS];
    coord_t mem_y [MAX_ATOMS];
    coord_t mem_z [MAX_ATOMS];

    // Updater writes win over loads
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MAX_ATOMS; i++) begin
                mem_x[i] <= '0;
                mem_y[i] <= '0;
                mem_z[i] <= '0;
            end
        end else if (upd_we_i) begin
            mem_x[upd_addr_i] <= upd_x_i;
            mem_y[upd_addr_i] <= upd_y_i;
            mem_z[upd_addr_i] <= upd_z_i;
        end else if (load_en_i) begin
            mem_x[load_addr_i] <= load_x_i;
            mem_y[load_addr_i] <= load_y_i;
            mem_z[load_addr_i] <= load_z_i;
        end
    end

    // ========================================
    // Asynchronous read ports
    // ========================================
    assign rd_a.x = mem_x[rd_a.addr];
    assign rd_a.y = mem_y[rd_a.addr];
    assign rd_a.z = mem_z[rd_a.addr];
    assign rd_b.x = mem_x[rd_b.addr];
    assign rd_b.y = mem_y[rd_b.addr];
    assign rd_b.z = mem_z[rd_b.addr];
    assign rd_c.x = mem_x[rd_c.addr];
    assign rd_c.y = mem_y[rd_c.addr];
    assign rd_c.z = mem_z[rd_c.addr];

    // Host read-back
    assign rd_x_o = mem_x[rd_addr_i];
    assign rd_y_o = mem_y[rd_addr_i];
    assign rd_z_o = mem_z[rd_addr_i];

endmodule

`default_nettype wire

/* bond_spring_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module bond_spring_unit (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           pair_go_i,
    coord_rd_if.client    pos_a,
    coord_rd_if.client    pos_b,
    pair_force_if.src     pair_o
);
    import md_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pair_o.valid <= 1'b0;
        end else begin
            pair_o.valid <= pair_go_i;
        end
    end

    // Force on atom a pulls it toward atom b
    // The pipe takes a new pair every cycle
    always_ff @(posedge clk) begin
        if (pair_go_i) begin
            pair_o.idx_a <= pos_a.addr;
            pair_o.idx_b <= pos_b.addr;
            pair_o.fx    <= q_mult(BOND_K, pos_b.x - pos_a.x);
            pair_o.fy    <= q_mult(BOND_K, pos_b.y - pos_a.y);
            pair_o.fz    <= q_mult(BOND_K, pos_b.z - pos_a.z);
        end
    end

endmodule

`default_nettype wire

/* force_accum.sv */
`timescale 1ns/10ps
`default_nettype none

module force_accum (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 clear_i,
    pair_force_if.dst           pair_i,
    input  md_pkg::atom_idx_t   rd_idx_i,
    output md_pkg::coord_t      fx_o,
    output md_pkg::coord_t      fy_o,
    output md_pkg::coord_t      fz_o
);
    import md_pkg::*;

    coord_t acc_x [MAX_ATOMS];
    coord_t acc_y [MAX_ATOMS];
    coord_t acc_z [MAX_ATOMS];

    // ========================================
    // Accumulator arrays
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MAX_ATOMS; i++) begin
                acc_x[i] <= '0;
                acc_y[i] <= '0;
                acc_z[i] <= '0;
            end
        end else if (clear_i) begin
            for (int i = 0; i < MAX_ATOMS; i++) begin
                acc_x[i] <= '0;
                acc_y[i] <= '0;
                acc_z[i] <= '0;
            end
        end else if (pair_i.valid) begin
            // Equal and opposite on the two ends of the bond
            acc_x[pair_i.idx_a] <= acc_x[pair_i.idx_a] + pair_i.fx;
            acc_y[pair_i.idx_a] <= acc_y[pair_i.idx_a] + pair_i.fy;
            acc_z[pair_i.idx_a] <= acc_z[pair_i.idx_a] + pair_i.fz;
            acc_x[pair_i.idx_b] <= acc_x[pair_i.idx_b] - pair_i.fx;
            acc_y[pair_i.idx_b] <= acc_y[pair_i.idx_b] - pair_i.fy;
            acc_z[pair_i.idx_b] <= acc_z[pair_i.idx_b] - pair_i.fz;
        end
    end

    // Combinational read for the position updater
    assign fx_o = acc_x[rd_idx_i];
    assign fy_o = acc_y[rd_idx_i];
    assign fz_o = acc_z[rd_idx_i];

endmodule

`default_nettype wire

/* position_updater.sv */
`timescale 1ns/10ps
`default_nettype none

module position_updater (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 apply_go_i,
    input  wire                 first_iter_i,
    input  wire                 cool_i,
    coord_rd_if.client          pos,
    output md_pkg::atom_idx_t   force_idx_o,
    input  md_pkg::coord_t      fx_i,
    input  md_pkg::coord_t      fy_i,
    input  md_pkg::coord_t      fz_i,
    output logic                we_o,
    output md_pkg::atom_idx_t   wr_addr_o,
    output md_pkg::coord_t      wr_x_o,
    output md_pkg::coord_t      wr_y_o,
    output md_pkg::coord_t      wr_z_o
);
    import md_pkg::*;

    coord_t step;

    // One gradient step along one axis, move bounded to MOVE_LIMIT
    function automatic coord_t moved(input coord_t p, input coord_t f, input coord_t s);
        coord_t m;
        m = q_mult(f, s);
        if (m > MOVE_LIMIT) begin
            m = MOVE_LIMIT;
        end else if (m < -MOVE_LIMIT) begin
            m = -MOVE_LIMIT;
        end
        return p + m;
    endfunction

    // Annealed step size
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step <= INITIAL_STEP;
        end else if (first_iter_i) begin
            step <= INITIAL_STEP;
        end else if (cool_i) begin
            step <= q_mult(step, COOLING_FACTOR);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            we_o <= 1'b0;
        end else begin
            we_o <= apply_go_i;
        end
    end

    // Write-back payload, one atom per cycle
    always_ff @(posedge clk) begin
        if (apply_go_i) begin
            wr_addr_o <= pos.addr;
            wr_x_o    <= moved(pos.x, fx_i, step);
            wr_y_o    <= moved(pos.y, fy_i, step);
            wr_z_o    <= moved(pos.z, fz_i, step);
        end
    end

    assign force_idx_o = pos.addr;

endmodule

`default_nettype wire

/* md_controller.sv */
`timescale 1ns/10ps
`default_nettype none

module md_controller (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 start_i,
    input  md_pkg::iter_t       max_iters_i,
    input  md_pkg::atom_idx_t   num_atoms_i,
    coord_rd_if.client          pair_rd_a,
    coord_rd_if.client          pair_rd_b,
    coord_rd_if.client          upd_rd,
    output logic                clear_o,
    output logic                pair_go_o,
    output logic                apply_go_o,
    output logic                first_iter_o,
    output logic                cool_o,
    output logic                done_o,
    output md_pkg::iter_t       iter_count_o
);
    import md_pkg::*;

    md_state_e state;
    atom_idx_t pair_idx;
    atom_idx_t atom_idx;
    iter_t     iter_next;
    logic      pair_last;
    logic      atom_last;

    assign iter_next = iter_count_o + iter_t'(1);
    assign pair_last = (pair_idx == num_atoms_i - atom_idx_t'(2));
    assign atom_last = (atom_idx == num_atoms_i - atom_idx_t'(1));

    // ========================================
    // Iteration FSM
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= IDLE;
            pair_idx     <= '0;
            atom_idx     <= '0;
            iter_count_o <= '0;
            done_o       <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                IDLE: begin
                    if (start_i) begin
                        iter_count_o <= '0;
                        state        <= CLEAR;
                    end
                end
                CLEAR: begin
                    pair_idx <= '0;
                    state    <= BOND;
                end
                // Pairs (i, i+1) issued back to back
                BOND: begin
                    if (pair_last) begin
                        state <= BOND_DRAIN;
                    end else begin
                        pair_idx <= pair_idx + atom_idx_t'(1);
                    end
                end
                // Last bond force lands in the accumulators
                BOND_DRAIN: begin
                    atom_idx <= '0;
                    state    <= APPLY;
                end
                APPLY: begin
                    if (atom_last) begin
                        state <= APPLY_DRAIN;
                    end else begin
                        atom_idx <= atom_idx + atom_idx_t'(1);
                    end
                end
                APPLY_DRAIN: begin
                    state <= COOL;
                end
                COOL: begin
                    iter_count_o <= iter_next;
                    if (iter_next >= max_iters_i) begin
                        done_o <= 1'b1;
                        state  <= IDLE;
                    end else begin
                        state <= CLEAR;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Phase enables straight from the state
    assign clear_o      = (state == CLEAR);
    assign pair_go_o    = (state == BOND);
    assign apply_go_o   = (state == APPLY);
    assign cool_o       = (state == COOL);
    assign first_iter_o = (state == CLEAR) && (iter_count_o == '0);

    assign pair_rd_a.addr = pair_idx;
    assign pair_rd_b.addr = pair_idx + atom_idx_t'(1);
    assign upd_rd.addr    = atom_idx;

endmodule

`default_nettype wire

/* md_top.sv */
`timescale 1ns/10ps
`default_nettype none

module md_top (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 start_i,
    input  md_pkg::iter_t       max_iters_i,
    input  md_pkg::atom_idx_t   num_atoms_i,
    input  wire                 load_en_i,
    input  md_pkg::atom_idx_t   load_addr_i,
    input  md_pkg::coord_t      load_x_i,
    input  md_pkg::coord_t      load_y_i,
    input  md_pkg::coord_t      load_z_i,
    input  md_pkg::atom_idx_t   rd_addr_i,
    output md_pkg::coord_t      rd_x_o,
    output md_pkg::coord_t      rd_y_o,
    output md_pkg::coord_t      rd_z_o,
    output logic                done_o,
    output md_pkg::iter_t       iter_count_o
);
    import md_pkg::*;

    // Bond read ports A and B, then the updater port C
    coord_rd_if   pair_rd [2] ();
    coord_rd_if   upd_rd ();
    pair_force_if bond_force ();

    logic      clear;
    logic      pair_go;
    logic      apply_go;
    logic      first_iter;
    logic      cool;
    atom_idx_t force_idx;
    coord_t    acc_fx;
    coord_t    acc_fy;
    coord_t    acc_fz;
    logic      upd_we;
    atom_idx_t upd_addr;
    coord_t    upd_x;
    coord_t    upd_y;
    coord_t    upd_z;

    md_controller u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .max_iters_i  (max_iters_i),
        .num_atoms_i  (num_atoms_i),
        .pair_rd_a    (pair_rd[0]),
        .pair_rd_b    (pair_rd[1]),
        .upd_rd       (upd_rd),
        .clear_o      (clear),
        .pair_go_o    (pair_go),
        .apply_go_o   (apply_go),
        .first_iter_o (first_iter),
        .cool_o       (cool),
        .done_o       (done_o),
        .iter_count_o (iter_count_o)
    );

    atom_regfile u_regfile (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_en_i   (load_en_i),
        .load_addr_i (load_addr_i),
        .load_x_i    (load_x_i),
        .load_y_i    (load_y_i),
        .load_z_i    (load_z_i),
        .upd_we_i    (upd_we),
        .upd_addr_i  (upd_addr),
        .upd_x_i     (upd_x),
        .upd_y_i     (upd_y),
        .upd_z_i     (upd_z),
        .rd_a        (pair_rd[0]),
        .rd_b        (pair_rd[1]),
        .rd_c        (upd_rd),
        .rd_addr_i   (rd_addr_i),
        .rd_x_o      (rd_x_o),
        .rd_y_o      (rd_y_o),
        .rd_z_o      (rd_z_o)
    );

    bond_spring_unit u_bond (
        .clk       (clk),
        .rst_n     (rst_n),
        .pair_go_i (pair_go),
        .pos_a     (pair_rd[0]),
        .pos_b     (pair_rd[1]),
        .pair_o    (bond_force)
    );

    force_accum u_accum (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear_i  (clear),
        .pair_i   (bond_force),
        .rd_idx_i (force_idx),
        .fx_o     (acc_fx),
        .fy_o     (acc_fy),
        .fz_o     (acc_fz)
    );

    position_updater u_update (
        .clk          (clk),
        .rst_n        (rst_n),
        .apply_go_i   (apply_go),
        .first_iter_i (first_iter),
        .cool_i       (cool),
        .pos          (upd_rd),
        .force_idx_o  (force_idx),
        .fx_i         (acc_fx),
        .fy_i         (acc_fy),
        .fz_i         (acc_fz),
        .we_o         (upd_we),
        .wr_addr_o    (upd_addr),
        .wr_x_o       (upd_x),
        .wr_y_o       (upd_y),
        .wr_z_o       (upd_z)
    );

endmodule

`default_nettype wire

/* md_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module md_assertions (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 clear_o,
    input  wire                 pair_go_o,
    input  wire                 apply_go_o,
    input  wire                 done_o
);

    // ========================================
    // Controller protocol
    // ========================================

    // Completion strobe is a single-cycle pulse
    assert property (@(posedge clk) disable iff (!rst_n) done_o |=> !done_o)
        else $error("done_o stayed high for more than one cycle");

    // A drain cycle separates the bond and apply phases
    assert property (@(posedge clk) disable iff (!rst_n) pair_go_o |=> !apply_go_o)
        else $error("apply_go followed pair_go without a drain cycle");

    // Accumulator clear lasts one cycle and opens the bond phase
    assert property (@(posedge clk) disable iff (!rst_n) clear_o |=> !clear_o && pair_go_o)
        else $error("clear_o was not followed by the bond phase");

endmodule

bind md_controller md_assertions u_assertions (
    .clk        (clk),
    .rst_n      (rst_n),
    .clear_o    (clear_o),
    .pair_go_o  (pair_go_o),
    .apply_go_o (apply_go_o),
    .done_o     (done_o)
);

`default_nettype wire

/* tb_md_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_md_top #(
    parameter logic [31:0] SEED = 32'd65398
);
    import md_pkg::*;

    localparam int CLK_PERIOD      = 10;
    localparam int NUM_RANDOM_RUNS = 4;
    localparam int MAX_RUN_ATOMS   = 20;
    localparam int MAX_RUN_ITERS   = 6;
    // Longest run from start to done
    localparam int RUN_CYCLES_MAX  = MAX_RUN_ITERS * (2 * MAX_RUN_ATOMS + 3) + 1;
    // Two cycles per atom for a load or read-back sweep
    localparam int SWEEP_CYCLES    = 2 * MAX_ATOMS;
    localparam int WATCHDOG_CYCLES = 3 * SWEEP_CYCLES
        + (NUM_RANDOM_RUNS + 3) * (RUN_CYCLES_MAX + 2 * SWEEP_CYCLES) + 500;

    logic      clk;
    logic      rst_n;
    logic      start_i;
    iter_t     max_iters_i;
    atom_idx_t num_atoms_i;
    logic      load_en_i;
    atom_idx_t load_addr_i;
    coord_t    load_x_i;
    coord_t    load_y_i;
    coord_t    load_z_i;
    atom_idx_t rd_addr_i;
    coord_t    rd_x_o;
    coord_t    rd_y_o;
    coord_t    rd_z_o;
    logic      done_o;
    iter_t     iter_count_o;

    logic [31:0] rng;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          test_err_start;

    // Reference copy of the coordinate store
    coord_t model_x [MAX_ATOMS];
    coord_t model_y [MAX_ATOMS];
    coord_t model_z [MAX_ATOMS];

    md_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .max_iters_i  (max_iters_i),
        .num_atoms_i  (num_atoms_i),
        .load_en_i    (load_en_i),
        .load_addr_i  (load_addr_i),
        .load_x_i     (load_x_i),
        .load_y_i     (load_y_i),
        .load_z_i     (load_z_i),
        .rd_addr_i    (rd_addr_i),
        .rd_x_o       (rd_x_o),
        .rd_y_o       (rd_y_o),
        .rd_z_o       (rd_z_o),
        .done_o       (done_o),
        .iter_count_o (iter_count_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    // ========================================
    // Random numbers and fixed-point model
    // ========================================
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // Uniform in [-4.0, 4.0)
    function automatic coord_t small_coord();
        return coord_t'(next_rand() & 32'h0007_FFFF) - 32'sh0004_0000;
    endfunction

    // Q16.16 product floored, low 32 bits kept
    function automatic coord_t fixed_mul(input coord_t a, input coord_t b);
        logic signed [63:0] p;
        p = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        p = p >>> 16;
        return p[31:0];
    endfunction

    function automatic coord_t clamp_move(input coord_t m);
        if (m > MOVE_LIMIT) begin
            return MOVE_LIMIT;
        end
        if (m < -MOVE_LIMIT) begin
            return -MOVE_LIMIT;
        end
        return m;
    endfunction

    task automatic model_run(input int n, input int iters);
        coord_t fx [MAX_ATOMS];
        coord_t fy [MAX_ATOMS];
        coord_t fz [MAX_ATOMS];
        coord_t f;
        coord_t step;
        step = INITIAL_STEP;
        for (int it = 0; it < iters; it++) begin
            for (int i = 0; i < MAX_ATOMS; i++) begin
                fx[i] = '0;
                fy[i] = '0;
                fz[i] = '0;
            end
            // Spring pulls each end toward the other
            for (int i = 0; i < n - 1; i++) begin
                f = fixed_mul(BOND_K, model_x[i + 1] - model_x[i]);
                fx[i] = fx[i] + f;
                fx[i + 1] = fx[i + 1] - f;
                f = fixed_mul(BOND_K, model_y[i + 1] - model_y[i]);
                fy[i] = fy[i] + f;
                fy[i + 1] = fy[i + 1] - f;
                f = fixed_mul(BOND_K, model_z[i + 1] - model_z[i]);
                fz[i] = fz[i] + f;
                fz[i + 1] = fz[i + 1] - f;
            end
            for (int i = 0; i < n; i++) begin
                model_x[i] = model_x[i] + clamp_move(fixed_mul(fx[i], step));
                model_y[i] = model_y[i] + clamp_move(fixed_mul(fy[i], step));
                model_z[i] = model_z[i] + clamp_move(fixed_mul(fz[i], step));
            end
            step = fixed_mul(step, COOLING_FACTOR);
        end
    endtask

    // ========================================
    // Checks and bus tasks
    // ========================================
    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_err_start) begin
            tests_failed++;
            $display("test %s: fail, %0d errors", name, errors - test_err_start);
        end else begin
            $display("test %s: pass", name);
        end
        test_err_start = errors;
    endtask

    task automatic load_atom(input int idx, input coord_t x, input coord_t y, input coord_t z);
        @(negedge clk);
        load_en_i   = 1'b1;
        load_addr_i = atom_idx_t'(idx);
        load_x_i    = x;
        load_y_i    = y;
        load_z_i    = z;
        @(negedge clk);
        load_en_i = 1'b0;
        model_x[idx] = x;
        model_y[idx] = y;
        model_z[idx] = z;
    endtask

    task automatic read_atom(input int idx, output coord_t x, output coord_t y,
                             output coord_t z);
        @(negedge clk);
        rd_addr_i = atom_idx_t'(idx);
        @(negedge clk);
        x = rd_x_o;
        y = rd_y_o;
        z = rd_z_o;
    endtask

    task automatic check_all_atoms(input string name);
        coord_t x;
        coord_t y;
        coord_t z;
        for (int a = 0; a < MAX_ATOMS; a++) begin
            read_atom(a, x, y, z);
            check_value($sformatf("%s atom%0d x", name, a), model_x[a], x);
            check_value($sformatf("%s atom%0d y", name, a), model_y[a], y);
            check_value($sformatf("%s atom%0d z", name, a), model_z[a], z);
        end
    endtask

    // Start a run, time done_o, then compare every atom with the model
    task automatic run_and_check(input string name, input int n, input int iters);
        int latency;
        int expected;
        expected = iters * (2 * n + 3) + 1;
        @(negedge clk);
        num_atoms_i = atom_idx_t'(n);
        max_iters_i = iter_t'(iters);
        start_i     = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        latency = 1;
        while (!done_o && latency < expected + 10) begin
            @(negedge clk);
            latency++;
        end
        if (!done_o) begin
            errors++;
            $display("run %s: done_o never arrived within %0d cycles", name, expected + 10);
        end else begin
            check_value({name, " done latency"}, 32'(expected), 32'(latency));
            check_value({name, " iter_count"}, 32'(iters), 32'(iter_count_o));
            @(negedge clk);
            check_value({name, " done width"}, 32'd0, 32'(done_o));
        end
        model_run(n, iters);
        check_all_atoms(name);
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        coord_t x0;
        coord_t x1;
        coord_t nx0;
        coord_t nx1;
        coord_t ny;
        coord_t nz;
        int     n;
        int     iters;
        string  name;

        rng            = SEED;
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        test_err_start = 0;
        rst_n       = 1'b0;
        start_i     = 1'b0;
        max_iters_i = '0;
        num_atoms_i = '0;
        load_en_i   = 1'b0;
        load_addr_i = '0;
        load_x_i    = '0;
        load_y_i    = '0;
        load_z_i    = '0;
        rd_addr_i   = '0;
        for (int a = 0; a < MAX_ATOMS; a++) begin
            model_x[a] = '0;
            model_y[a] = '0;
            model_z[a] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_value("reset done_o", 32'd0, 32'(done_o));
        check_value("reset iter_count", 32'd0, 32'(iter_count_o));
        check_all_atoms("reset");
        end_test("reset");

        for (int a = 0; a < MAX_ATOMS; a++) begin
            nx0 = small_coord();
            ny  = small_coord();
            nz  = small_coord();
            load_atom(a, nx0, ny, nz);
        end
        check_all_atoms("load_readback");
        end_test("load_readback");

        // Two atoms at least 4.0 apart along x
        x0 = -32'sh0002_0000 - coord_t'(next_rand() & 32'h0000_FFFF);
        x1 = 32'sh0002_0000 + coord_t'(next_rand() & 32'h0000_FFFF);
        load_atom(0, x0, small_coord(), small_coord());
        load_atom(1, x1, small_coord(), small_coord());
        run_and_check("two_atom", 2, 1);
        read_atom(0, nx0, ny, nz);
        read_atom(1, nx1, ny, nz);
        check_value("two_atom approach", 32'd1, 32'((nx1 - nx0) < (x1 - x0)));
        end_test("two_atom");

        for (int r = 0; r < NUM_RANDOM_RUNS; r++) begin
            n     = 2 + int'(next_rand() % 32'd19);
            iters = 1 + int'(next_rand() % 32'd6);
            for (int a = 0; a < n; a++) begin
                nx0 = small_coord();
                ny  = small_coord();
                nz  = small_coord();
                load_atom(a, nx0, ny, nz);
            end
            name = $sformatf("random_run%0d", r);
            run_and_check(name, n, iters);
            end_test(name);
        end

        // Separation above 600 gives a move well past the limit
        x0 = -32'sh012C_0000 - coord_t'(next_rand() & 32'h0000_FFFF);
        x1 = 32'sh012C_0000 + coord_t'(next_rand() & 32'h0000_FFFF);
        load_atom(0, x0, small_coord(), small_coord());
        load_atom(1, x1, small_coord(), small_coord());
        run_and_check("clamp", 2, 1);
        read_atom(0, nx0, ny, nz);
        read_atom(1, nx1, ny, nz);
        check_value("clamp atom0 x move", MOVE_LIMIT, nx0 - x0);
        check_value("clamp atom1 x move", MOVE_LIMIT, x1 - nx1);
        end_test("clamp");

        run_and_check("done_timing", MAX_RUN_ATOMS, MAX_RUN_ITERS);
        end_test("done_timing");

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
md_pkg.sv
md_ifs.sv
atom_regfile.sv
bond_spring_unit.sv
force_accum.sv
position_updater.sv
md_controller.sv
md_top.sv
md_assertions.sv
tb_md_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_md_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SEED      ?= 65398

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG SEED"

build:
	$(VERILATOR) --binary --timing --assert -Mdir $(BUILD_DIR) \
		--top-module $(TOP) -GSEED=$(SEED) -f $(FILELIST)

test: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "TB PASSED" $(LOG); then \
		echo "no verdict found in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
